/* logic/capture_pkg.sv */
package capture_pkg;

    localparam int PIXEL_BITS     = 10;
    localparam int WORD_BITS      = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_BITS      = WORD_BITS / BYTES_PER_WORD;

    // address field wide enough for any ADDR_BITS up to 16; modules use the low bits.
    localparam int ADDR_FIELD_BITS = 16;

    typedef enum logic [1:0] {
        CAPTURE_IDLE,
        CAPTURE_ARMED,
        CAPTURE_RUNNING
    } capture_state_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITE,
        MEM_READ
    } mem_op_t;

    typedef struct packed {
        logic [PIXEL_BITS-1:0] red;
        logic [PIXEL_BITS-1:0] green;
        logic [PIXEL_BITS-1:0] blue;
    } camera_pixel_t;

    typedef struct packed {
        logic                       valid;
        logic [ADDR_FIELD_BITS-1:0] addr;
        logic [WORD_BITS-1:0]       data;
        logic [BYTES_PER_WORD-1:0]  byte_en;
    } pixel_write_t;

    typedef struct packed {
        mem_op_t                    op;
        logic [ADDR_FIELD_BITS-1:0] addr;
        logic [WORD_BITS-1:0]       data;
        logic [BYTES_PER_WORD-1:0]  byte_en;
    } mem_request_t;

endpackage

/* logic/capture_control.sv */
`timescale 1ns/1ps

module capture_control import capture_pkg::*; (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic start_capture,
    input  logic frame_valid,
    output logic capture_active,
    output logic frame_done
);

    capture_state_t state;
    logic [1:0]     frame_valid_history; // older sample in bit 1.

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state               <= CAPTURE_IDLE;
            frame_valid_history <= 2'b00;
            frame_done          <= 1'b0;
        end else begin
            frame_valid_history <= {frame_valid_history[0], frame_valid};
            frame_done          <= 1'b0;

            case (state)
                CAPTURE_IDLE: begin
                    if (start_capture) begin
                        state <= CAPTURE_ARMED;
                    end
                end

                CAPTURE_ARMED: begin
                    if (frame_valid_history == 2'b01) begin // rising edge.
                        state <= CAPTURE_RUNNING;
                    end
                end

                CAPTURE_RUNNING: begin
                    // start strobes are ignored here.
                    if (frame_valid_history == 2'b10) begin
                        state      <= CAPTURE_IDLE;
                        frame_done <= 1'b1;
                    end
                end

                default: begin
                    state <= CAPTURE_IDLE;
                end
            endcase
        end
    end

    assign capture_active = (state == CAPTURE_RUNNING);

endmodule

/* logic/pixel_packer.sv */
`timescale 1ns/1ps

module pixel_packer import capture_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic               clock_in,
    input  logic               reset_n_in,
    input  camera_pixel_t      pixel,
    input  logic               line_valid,
    input  logic               frame_valid,
    input  logic               capture_active,
    output pixel_write_t       pixel_write,
    output logic [ADDR_BITS:0] words_written
);

    localparam int COUNT_BITS = $clog2(BYTES_PER_WORD);
    localparam logic [COUNT_BITS-1:0] LAST_BYTE = COUNT_BITS'(BYTES_PER_WORD - 1);

    logic [7:0]                rgb332;
    logic                      pixel_taken;
    logic                      line_end;
    logic                      capture_start;
    logic                      line_valid_prev;
    logic                      active_prev;
    logic [COUNT_BITS-1:0]     byte_count;
    logic [WORD_BITS-1:0]      word_data;
    logic [WORD_BITS-1:0]      word_next;
    logic [BYTES_PER_WORD-1:0] fill_mask;
    logic [ADDR_BITS-1:0]      word_addr;

    // top 3 red, 3 green, 2 blue.
    assign rgb332 = {pixel.red[PIXEL_BITS-1 -: 3],
                     pixel.green[PIXEL_BITS-1 -: 3],
                     pixel.blue[PIXEL_BITS-1 -: 2]};

    assign pixel_taken   = line_valid && frame_valid && capture_active;
    assign line_end      = line_valid_prev && !line_valid;
    assign capture_start = capture_active && !active_prev;

    always_comb begin
        word_next = word_data;
        word_next[byte_count * BYTE_BITS +: BYTE_BITS] = rgb332; // pixel 0 in byte 0.
    end

    // bytes already filled in the current word.
    always_comb begin
        fill_mask = '0;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (b < byte_count) begin
                fill_mask[b] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            line_valid_prev   <= 1'b0;
            active_prev       <= 1'b0;
            byte_count        <= '0;
            word_addr         <= '0;
            words_written     <= '0;
            pixel_write.valid <= 1'b0;
        end else begin
            line_valid_prev   <= line_valid;
            active_prev       <= capture_active;
            pixel_write.valid <= 1'b0;

            if (capture_start) begin
                byte_count    <= '0;
                word_addr     <= '0;
                words_written <= '0;
            end else if (pixel_taken) begin
                word_data <= word_next;
                if (byte_count == LAST_BYTE) begin
                    byte_count          <= '0;
                    pixel_write.valid   <= 1'b1;
                    pixel_write.addr    <= ADDR_FIELD_BITS'(word_addr);
                    pixel_write.data    <= word_next;
                    pixel_write.byte_en <= '1;
                    word_addr           <= word_addr + 1'b1; // wraps at depth.
                    words_written       <= words_written + 1'b1;
                end else begin
                    byte_count <= byte_count + 1'b1;
                end
            end else if (line_end && byte_count != '0) begin
                // partial word at end of line.
                byte_count          <= '0;
                pixel_write.valid   <= 1'b1;
                pixel_write.addr    <= ADDR_FIELD_BITS'(word_addr);
                pixel_write.data    <= word_data;
                pixel_write.byte_en <= fill_mask;
                word_addr           <= word_addr + 1'b1;
                words_written       <= words_written + 1'b1;
            end
        end
    end

endmodule

/* logic/frame_memory_arbiter.sv */
`timescale 1ns/1ps

module frame_memory_arbiter import capture_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clock_in,
    input  logic                 reset_n_in,
    input  pixel_write_t         pixel_write,
    input  logic                 read_request,
    input  logic [ADDR_BITS-1:0] read_address,
    output logic                 read_grant,
    output mem_request_t         mem_request,
    input  logic [WORD_BITS-1:0] mem_read_data,
    output logic [WORD_BITS-1:0] read_data,
    output logic                 read_valid
);

    logic read_issued;

    // camera cannot stall, so a write always takes the slot.
    assign read_grant = read_request && !pixel_write.valid;

    always_comb begin
        mem_request.op      = MEM_NONE;
        mem_request.addr    = '0;
        mem_request.data    = '0;
        mem_request.byte_en = '0;

        if (pixel_write.valid) begin
            mem_request.op      = MEM_WRITE;
            mem_request.addr    = pixel_write.addr;
            mem_request.data    = pixel_write.data;
            mem_request.byte_en = pixel_write.byte_en;
        end else if (read_request) begin
            mem_request.op   = MEM_READ;
            mem_request.addr = ADDR_FIELD_BITS'(read_address);
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            read_issued <= 1'b0;
        end else begin
            read_issued <= read_grant; // memory answers next cycle.
        end
    end

    assign read_valid = read_issued;
    assign read_data  = mem_read_data;

endmodule

/* logic/frame_memory.sv */
`timescale 1ns/1ps

module frame_memory import capture_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clock_in,
    input  mem_request_t         mem_request,
    output logic [WORD_BITS-1:0] read_data
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [WORD_BITS-1:0] words [DEPTH];
    logic [ADDR_BITS-1:0] index;

    assign index = mem_request.addr[ADDR_BITS-1:0];

    always_ff @(posedge clock_in) begin
        if (mem_request.op == MEM_WRITE) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (mem_request.byte_en[b]) begin
                    words[index][b * BYTE_BITS +: BYTE_BITS] <=
                        mem_request.data[b * BYTE_BITS +: BYTE_BITS];
                end
            end
        end

        if (mem_request.op == MEM_READ) begin
            read_data <= words[index]; // one cycle latency.
        end
    end

endmodule

/* logic/camera_capture.sv */
`timescale 1ns/1ps

module camera_capture import capture_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clock_in,
    input  logic                 reset_n_in,

    input  camera_pixel_t        pixel,
    input  logic                 line_valid,
    input  logic                 frame_valid,
    input  logic                 start_capture,

    input  logic                 read_request,
    input  logic [ADDR_BITS-1:0] read_address,

    output logic                 capture_active,
    output logic                 frame_done,
    output logic [ADDR_BITS:0]   words_written,
    output logic                 read_grant,
    output logic [WORD_BITS-1:0] read_data,
    output logic                 read_valid
);

    pixel_write_t         pixel_write;
    mem_request_t         mem_request;
    logic [WORD_BITS-1:0] mem_read_data;

    capture_control u_capture_control (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .start_capture  (start_capture),
        .frame_valid    (frame_valid),
        .capture_active (capture_active),
        .frame_done     (frame_done)
    );

    pixel_packer #(
        .ADDR_BITS (ADDR_BITS)
    ) u_pixel_packer (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .pixel          (pixel),
        .line_valid     (line_valid),
        .frame_valid    (frame_valid),
        .capture_active (capture_active),
        .pixel_write    (pixel_write),
        .words_written  (words_written)
    );

    frame_memory_arbiter #(
        .ADDR_BITS (ADDR_BITS)
    ) u_frame_memory_arbiter (
        .clock_in      (clock_in),
        .reset_n_in    (reset_n_in),
        .pixel_write   (pixel_write),
        .read_request  (read_request),
        .read_address  (read_address),
        .read_grant    (read_grant),
        .mem_request   (mem_request),
        .mem_read_data (mem_read_data),
        .read_data     (read_data),
        .read_valid    (read_valid)
    );

    frame_memory #(
        .ADDR_BITS (ADDR_BITS)
    ) u_frame_memory (
        .clock_in    (clock_in),
        .mem_request (mem_request),
        .read_data   (mem_read_data)
    );

endmodule

/* tests/camera_capture_props.sv */
`timescale 1ns/1ps

module camera_capture_props import capture_pkg::*; (
    input logic    clock_in,
    input logic    reset_n_in,
    input logic    write_valid,
    input mem_op_t mem_op,
    input logic    read_grant,
    input logic    read_valid,
    input logic    start_capture,
    input logic    capture_active,
    input logic    frame_done
);

    logic start_seen; // a strobe was taken while not capturing.

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            start_seen <= 1'b0;
        end else if (start_capture && !capture_active) begin
            start_seen <= 1'b1;
        end else if (frame_done) begin
            start_seen <= 1'b0;
        end
    end

    // a grant must be a read at the memory, so it can never share a write slot.
    grant_not_during_write: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        read_grant |-> (mem_op == MEM_READ))
        else $error("read_grant raised while the memory was not issued a read");

    write_takes_slot: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        write_valid |-> (mem_op == MEM_WRITE))
        else $error("capture write did not reach the memory");

    valid_after_grant: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        read_grant |=> read_valid)
        else $error("read_valid missing one cycle after read_grant");

    valid_only_after_grant: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        read_valid |-> $past(read_grant))
        else $error("read_valid without a grant in the previous cycle");

    done_single_pulse: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        frame_done |=> !frame_done)
        else $error("frame_done longer than one cycle");

    active_needs_start: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        $rose(capture_active) |-> start_seen)
        else $error("capture_active rose without a start strobe");

endmodule

bind camera_capture camera_capture_props u_camera_capture_props (
    .clock_in       (clock_in),
    .reset_n_in     (reset_n_in),
    .write_valid    (pixel_write.valid),
    .mem_op         (mem_request.op),
    .read_grant     (read_grant),
    .read_valid     (read_valid),
    .start_capture  (start_capture),
    .capture_active (capture_active),
    .frame_done     (frame_done)
);

/* tests/camera_capture_tb.sv */
`timescale 1ns/1ps

module camera_capture_tb import capture_pkg::*; ();

    localparam int ADDR_BITS  = 8;
    localparam int DEPTH      = 2 ** ADDR_BITS;
    localparam int CLOCK_HALF = 2;
    localparam int LEAD       = 4; // line_valid low after frame_valid rises.
    localparam int MAX_CMDS   = 128;

    logic                 clock_in;
    logic                 reset_n_in;
    camera_pixel_t        pixel;
    logic                 line_valid;
    logic                 frame_valid;
    logic                 start_capture;
    logic                 read_request;
    logic [ADDR_BITS-1:0] read_address;
    logic                 capture_active;
    logic                 frame_done;
    logic [ADDR_BITS:0]   words_written;
    logic                 read_grant;
    logic [WORD_BITS-1:0] read_data;
    logic                 read_valid;

    logic [WORD_BITS-1:0] ref_mem [DEPTH];
    bit                   ref_known [DEPTH];
    integer               seed = 32'h15c5_e2d4;
    int                   cmd_kind [MAX_CMDS]; // 0 arm, 1 frame, 2 read, 3 hostread.
    int                   cmd_a [MAX_CMDS];
    int                   cmd_b [MAX_CMDS];
    int                   cmd_c [MAX_CMDS];
    int                   cmd_d [MAX_CMDS];
    int                   cmd_count = 0;
    int                   watchdog_cycles = 0;
    bit                   vectors_loaded = 1'b0;
    bit                   armed = 1'b0;
    int                   done_count = 0;
    logic [ADDR_BITS:0]   done_words = '0;
    bit                   active_seen = 1'b0;
    int                   pending_base = 0;
    int                   pending_count = 0;

    camera_capture #(
        .ADDR_BITS (ADDR_BITS)
    ) DUT (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .pixel          (pixel),
        .line_valid     (line_valid),
        .frame_valid    (frame_valid),
        .start_capture  (start_capture),
        .read_request   (read_request),
        .read_address   (read_address),
        .capture_active (capture_active),
        .frame_done     (frame_done),
        .words_written  (words_written),
        .read_grant     (read_grant),
        .read_data      (read_data),
        .read_valid     (read_valid)
    );

    initial clock_in = 1'b0;
    always #CLOCK_HALF clock_in = ~clock_in;

    always @(posedge clock_in) begin
        if (frame_done) begin
            done_count = done_count + 1;
            done_words = words_written; // count held at frame_done.
        end
        if (capture_active) begin
            active_seen = 1'b1;
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
                              input logic [WORD_BITS-1:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_count(input string name, input logic [ADDR_BITS:0] got,
                               input logic [ADDR_BITS:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, expected));
        end
    endtask

    // next drive point, just after a rising edge.
    task automatic tick();
        @(posedge clock_in);
        #1;
    endtask

    task automatic arm_capture();
        start_capture = 1'b1;
        tick();
        start_capture = 1'b0;
        armed = 1'b1;
    endtask

    task automatic host_read(input int addr);
        int                   waited;
        logic [WORD_BITS-1:0] expected;
        if (!ref_known[addr]) begin
            fail_run($sformatf("host read of word %0d that was never fully written", addr));
        end
        expected     = ref_mem[addr];
        read_request = 1'b1;
        read_address = ADDR_BITS'(addr);
        waited       = 0;
        @(posedge clock_in);
        while (!read_grant) begin
            waited++;
            if (waited > 32) begin
                fail_run("read_grant never arrived for a pending host read");
            end
            @(posedge clock_in);
        end
        #1;
        read_request = 1'b0;
        @(posedge clock_in);
        check_flag("read_valid", read_valid, 1'b1);
        check_word("read_data", read_data, expected);
        check_flag("read_grant", read_grant, 1'b0);
        #1;
    endtask

    task automatic read_range(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            host_read((base + i) % DEPTH);
        end
    endtask

    task automatic reads_during_frame(input int base, input int count);
        repeat (LEAD + 2) tick();
        read_range(base, count);
    endtask

    task automatic store_word(input int addr, input logic [WORD_BITS-1:0] word,
                              input logic [BYTES_PER_WORD-1:0] en);
        for (int k = 0; k < BYTES_PER_WORD; k++) begin
            if (en[k]) begin
                ref_mem[addr][k * 8 +: 8] = word[k * 8 +: 8];
            end
        end
        if (en == '1) begin
            ref_known[addr] = 1'b1;
        end
    endtask

    task automatic drive_frame(input int lines, input int width, input int gap,
                               input int midarm);
        bit                        captured;
        int                        addr;
        int                        words;
        int                        b;
        int                        start_done;
        int                        waited;
        logic [31:0]               rnd;
        camera_pixel_t             p;
        logic [WORD_BITS-1:0]      word;
        logic [BYTES_PER_WORD-1:0] en;
        captured    = armed;
        armed       = 1'b0;
        active_seen = 1'b0;
        start_done  = done_count;
        addr        = 0;
        words       = 0;
        word        = '0;
        en          = '0;
        frame_valid = 1'b1;
        repeat (LEAD) tick();
        for (int l = 0; l < lines; l++) begin
            for (int i = 0; i < width; i++) begin
                rnd        = $random(seed);
                p          = rnd[3 * PIXEL_BITS - 1:0];
                pixel      = p;
                line_valid = 1'b1;
                if (captured) begin
                    b = i % BYTES_PER_WORD;
                    if (b == 0) begin
                        word = '0;
                        en   = '0;
                    end
                    word[b * 8 +: 8] = {3'(p.red >> (PIXEL_BITS - 3)),
                                        3'(p.green >> (PIXEL_BITS - 3)),
                                        2'(p.blue >> (PIXEL_BITS - 2))};
                    en[b] = 1'b1;
                    if (b == BYTES_PER_WORD - 1 || i == width - 1) begin
                        store_word(addr, word, en);
                        addr = (addr + 1) % DEPTH;
                        words++;
                    end
                end
                tick();
            end
            line_valid = 1'b0;
            if (midarm != 0 && l == lines / 2) begin
                start_capture = 1'b1;
                if (!captured) begin
                    armed = 1'b1; // idle mid-frame, so this arms the next frame.
                end
            end
            tick();
            start_capture = 1'b0;
            repeat (gap - 1) tick();
        end
        frame_valid = 1'b0;
        if (captured) begin
            waited = 0;
            while (done_count == start_done) begin
                waited++;
                if (waited > 16) begin
                    fail_run("frame_done did not pulse after an armed frame");
                end
                tick();
            end
            tick();
            check_flag("capture_active", capture_active, 1'b0);
            check_count("words_written", done_words, (ADDR_BITS + 1)'(words));
        end else begin
            repeat (8) tick();
            check_flag("capture_active", active_seen, 1'b0);
        end
        repeat (gap) tick();
        check_flag("frame_done count", done_count == start_done + int'(captured), 1'b1);
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [63:0] op_word;
        string       rest;
        fd = $fopen("tests/capture_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("could not open tests/capture_vectors.txt");
        end
        while (!$feof(fd)) begin
            op_word = '0;
            a       = 0;
            b       = 0;
            c       = 0;
            d       = 0;
            code    = $fscanf(fd, "%s", op_word);
            if (code != 1) begin
                break;
            end
            if (op_word == "#") begin
                code = $fgets(rest, fd);
            end else begin
                if (op_word == "arm") begin
                    cmd_kind[cmd_count] = 0;
                    watchdog_cycles += 4;
                end else if (op_word == "frame") begin
                    code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                    cmd_kind[cmd_count] = 1;
                    watchdog_cycles += a * (b + c) + LEAD + 2 * c + 32;
                end else if (op_word == "read") begin
                    code = $fscanf(fd, "%d %d", a, b);
                    cmd_kind[cmd_count] = 2;
                    watchdog_cycles += 4 * b + 4;
                end else if (op_word == "hostread") begin
                    code = $fscanf(fd, "%d %d", a, b);
                    cmd_kind[cmd_count] = 3;
                    watchdog_cycles += 8 * b + 16;
                end else begin
                    fail_run("unknown command in the vectors file");
                end
                cmd_a[cmd_count] = a;
                cmd_b[cmd_count] = b;
                cmd_c[cmd_count] = c;
                cmd_d[cmd_count] = d;
                cmd_count++;
            end
        end
        $fclose(fd);
    endtask

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (watchdog_cycles * 2 + 500) @(posedge clock_in);
        $display("watchdog expired before all vectors were run");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        reset_n_in    = 1'b0;
        pixel         = '0;
        line_valid    = 1'b0;
        frame_valid   = 1'b0;
        start_capture = 1'b0;
        read_request  = 1'b0;
        read_address  = '0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (8) @(posedge clock_in);
        #1;
        reset_n_in = 1'b1;
        tick();
        for (int n = 0; n < cmd_count; n++) begin
            case (cmd_kind[n])
                0: arm_capture();
                1: begin
                    if (pending_count > 0) begin
                        fork
                            drive_frame(cmd_a[n], cmd_b[n], cmd_c[n], cmd_d[n]);
                            reads_during_frame(pending_base, pending_count);
                        join
                        pending_count = 0;
                    end else begin
                        drive_frame(cmd_a[n], cmd_b[n], cmd_c[n], cmd_d[n]);
                    end
                end
                2: read_range(cmd_a[n], cmd_b[n]);
                default: begin
                    pending_base  = cmd_a[n];
                    pending_count = cmd_b[n];
                end
            endcase
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tests/capture_vectors.txt */
# columns: command then fields
# arm | frame lines width gap midarm | read base count | hostread base count
# a first armed frame fills words 0 to 127
arm
frame 16 32 4 0
read 0 64
read 64 64
# frame without an arm writes nothing
frame 4 16 4 0
read 0 32
# armed frame, width a multiple of four
arm
frame 8 16 5 0
read 0 40
# width 10 flushes two-pixel words at each line end
arm
frame 8 10 4 0
read 0 32
# width 6 gives one full and one half word per line
arm
frame 5 6 3 0
read 0 24
# arm strobe inside a frame captures only the next frame
frame 6 8 4 1
read 0 16
frame 8 16 4 1
read 0 40
# idle again, so this frame is not captured
frame 4 8 4 0
read 0 32
# host reads while a capture is writing
hostread 64 40
arm
frame 4 16 4 0
read 0 16
# odd width with host reads above the written range
hostread 32 20
arm
frame 6 7 3 0
read 0 16
# unarmed frame with host reads in flight
hostread 0 24
frame 3 12 4 0
read 100 28
# final partial frame with width 1
arm
frame 4 1 3 0
read 0 8

/* build.f */
logic/capture_pkg.sv
logic/capture_control.sv
logic/pixel_packer.sv
logic/frame_memory_arbiter.sv
logic/frame_memory.sv
logic/camera_capture.sv
tests/camera_capture_props.sv
tests/camera_capture_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module camera_capture_tb \
    -f build.f \
    -o camera_capture_sim

./obj_dir/camera_capture_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi
